/* hdl/addrUnitPkg.sv */
/* Shared types and constants of the vector address unit. Pages are fixed at 4 KB
   and region bounds are fixed constants, so no run-time remapping exists. */

package addrUnitPkg;

  // lane and width constants
  localparam int NUM_LANES = 4;
  localparam int ADDR_W    = 32;
  localparam int PAGE_BITS = 12;
  localparam int PN_W      = ADDR_W - PAGE_BITS;
  localparam int TID_W     = 2;

  typedef logic [ADDR_W-1:0]    vAddrT;
  typedef logic [ADDR_W-1:0]    pAddrT;
  typedef logic [PN_W-1:0]      vpnT;
  typedef logic [PN_W-1:0]      pfnT;
  typedef logic [TID_W-1:0]     tidT;
  typedef logic [NUM_LANES-1:0] laneMaskT;

  // loads first, then stores
  typedef enum logic [2:0] {
    opLw, opLh, opLhu, opLb, opLbu, opSw, opSh, opSb
  } memOpT;

  typedef enum logic [2:0] {
    regNone, regMapped, regUncached, regDebug, regCached
  } regionT;

  typedef enum logic [1:0] {
    causeNone, causeTlb, causeAlign
  } causeT;

  // lower bound of each virtual region
  localparam vAddrT VADR_MAPPED   = 32'h4000_0000;
  localparam vAddrT VADR_UNCACHED = 32'hA000_0000;
  localparam vAddrT VADR_DEBUG    = 32'hB000_0000;
  localparam vAddrT VADR_CACHED   = 32'hC000_0000;

  // debug window lands here physically
  localparam pAddrT DEBUG_PBASE = 32'h1F00_0000;

  // log2 of the access size in bytes
  function automatic logic [1:0] opSizeLog2(memOpT op);
    case (op)
      opLw, opSw:        return 2'd2;
      opLh, opLhu, opSh: return 2'd1;
      default:           return 2'd0;
    endcase
  endfunction

  function automatic logic opIsStore(memOpT op);
    return op inside {opSw, opSh, opSb};
  endfunction

endpackage

/* hdl/addrGenStage.sv */
/* Stage 1: lane address generation and region decode. Inputs are plain strobes
   with no back-pressure; a cancel on the arriving thread drops the op at once. */

`timescale 1ns/1ns

module addrGenStage import addrUnitPkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     opValid,
  input  memOpT    opCode,
  input  tidT      opTid,
  input  vAddrT    laneBase [NUM_LANES],
  input  vAddrT    opOffset,
  input  laneMaskT laneEn,
  input  logic     isVector,
  input  logic     isBurst,
  input  logic     cancelValid,
  input  tidT      cancelTid,
  output logic     genValid,
  output memOpT    genOp,
  output tidT      genTid,
  output vAddrT    genAddr [NUM_LANES],
  output regionT   genRegion [NUM_LANES]
);

  vAddrT  nextAddr [NUM_LANES];
  regionT nextRegion [NUM_LANES];
  logic   opCancel;

  // arriving op killed on the same edge
  assign opCancel = cancelValid && (cancelTid == opTid);

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      nextAddr[i] = laneBase[i] + opOffset;
      // burst lanes step by the access size
      if (isBurst) begin
        nextAddr[i] = nextAddr[i] + (vAddrT'(i) << opSizeLog2(opCode));
      end
      // highest bound checked first
      if (nextAddr[i] >= VADR_CACHED) begin
        nextRegion[i] = regCached;
      end else if (nextAddr[i] >= VADR_DEBUG) begin
        nextRegion[i] = regDebug;
      end else if (nextAddr[i] >= VADR_UNCACHED) begin
        nextRegion[i] = regUncached;
      end else if (nextAddr[i] >= VADR_MAPPED) begin
        nextRegion[i] = regMapped;
      end else begin
        nextRegion[i] = regNone;
      end
      // disabled lanes and scalar lanes past 0 do nothing
      if (!laneEn[i] || (!isVector && i != 0)) begin
        nextRegion[i] = regNone;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      genValid <= 1'b0;
    end else begin
      genValid <= opValid && !opCancel;
    end
  end

  // op fields qualified by genValid
  always_ff @(posedge clk) begin
    genOp     <= opCode;
    genTid    <= opTid;
    genAddr   <= nextAddr;
    genRegion <= nextRegion;
  end

endmodule

/* hdl/tlbRequest.sv */
/* Stage 2: one TLB request per op, for the page of the lowest mapped lane.
   Repeat requests for the last requested page are dropped; the TLB answers 1 cycle on. */

`timescale 1ns/1ns

module tlbRequest import addrUnitPkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   genValid,
  input  memOpT  genOp,
  input  tidT    genTid,
  input  vAddrT  genAddr [NUM_LANES],
  input  regionT genRegion [NUM_LANES],
  input  logic   cancelValid,
  input  tidT    cancelTid,
  output logic   tlbReq,
  output vpnT    tlbVpn,
  output tidT    tlbTid,
  output logic   reqValid,
  output memOpT  reqOp,
  output tidT    reqTid,
  output vAddrT  reqAddr [NUM_LANES],
  output regionT reqRegion [NUM_LANES],
  output vpnT    reqVpn
);

  logic hasMapped;
  vpnT  pageVpn;
  // last page sent to the TLB
  logic lastVld;
  vpnT  lastVpn;

  // walk down so the lowest mapped lane wins
  always_comb begin
    hasMapped = 1'b0;
    pageVpn   = '0;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (genRegion[i] == regMapped) begin
        hasMapped = 1'b1;
        pageVpn   = genAddr[i][ADDR_W-1:PAGE_BITS];
      end
    end
  end

  // same page as last time needs no new lookup
  assign tlbReq = genValid && hasMapped && (!lastVld || pageVpn != lastVpn);
  assign tlbVpn = pageVpn;
  assign tlbTid = genTid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqValid <= 1'b0;
      lastVld  <= 1'b0;
    end else begin
      reqValid <= genValid && !(cancelValid && cancelTid == genTid);
      if (tlbReq) begin
        lastVld <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tlbReq) begin
      lastVpn <= pageVpn;
    end
    reqOp     <= genOp;
    reqTid    <= genTid;
    reqAddr   <= genAddr;
    reqRegion <= genRegion;
    reqVpn    <= pageVpn;
  end

endmodule

/* hdl/addrTranslate.sv */
/* Stage 3: lane translation, alignment check and one cause per op. The held
   translation is the last TLB answer, with no page tag; mapped lanes follow its cached bit. */

`timescale 1ns/1ns

module addrTranslate import addrUnitPkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     reqValid,
  input  memOpT    reqOp,
  input  tidT      reqTid,
  input  vAddrT    reqAddr [NUM_LANES],
  input  regionT   reqRegion [NUM_LANES],
  input  vpnT      reqVpn,
  input  logic     tlbRsp,
  input  pfnT      tlbPfn,
  input  logic     tlbCached,
  input  logic     tlbFault,
  input  logic     cancelValid,
  input  tidT      cancelTid,
  output logic     resultValid,
  output tidT      resultTid,
  output logic     resultStore,
  output pAddrT    lanePAddr [NUM_LANES],
  output laneMaskT laneValid,
  output laneMaskT laneUncached,
  output causeT    resultCause
);

  // held translation
  logic heldValid;
  pfnT  heldPfn;
  logic heldCached;
  logic heldFault;
  // live answer takes priority over held one
  logic curValid;
  pfnT  curPfn;
  logic curCached;
  logic curFault;

  pAddrT    nextPAddr [NUM_LANES];
  laneMaskT nextValid;
  laneMaskT nextUncached;
  causeT    nextCause;
  logic     anyMapped;
  logic     misAlign;
  logic [1:0] sizeLog2;

  assign curValid  = tlbRsp || heldValid;
  assign curPfn    = tlbRsp ? tlbPfn : heldPfn;
  assign curCached = tlbRsp ? tlbCached : heldCached;
  assign curFault  = tlbRsp ? tlbFault : heldFault;
  assign sizeLog2  = opSizeLog2(reqOp);

  always_comb begin
    anyMapped    = 1'b0;
    misAlign     = 1'b0;
    nextValid    = '0;
    nextUncached = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      nextPAddr[i] = '0;
      case (reqRegion[i])
        regMapped: begin
          anyMapped = 1'b1;
          // only the requested page can be translated
          if (curValid && reqAddr[i][ADDR_W-1:PAGE_BITS] == reqVpn) begin
            nextPAddr[i]    = {curPfn, reqAddr[i][PAGE_BITS-1:0]};
            nextValid[i]    = 1'b1;
            nextUncached[i] = !curCached;
          end
        end
        regUncached: begin
          nextPAddr[i]    = reqAddr[i] - VADR_UNCACHED;
          nextValid[i]    = 1'b1;
          nextUncached[i] = 1'b1;
        end
        regDebug: begin
          nextPAddr[i]    = DEBUG_PBASE + (reqAddr[i] - VADR_DEBUG);
          nextValid[i]    = 1'b1;
          nextUncached[i] = 1'b1;
        end
        regCached: begin
          nextPAddr[i] = reqAddr[i] - VADR_CACHED;
          nextValid[i] = 1'b1;
        end
        default: begin
          nextValid[i] = 1'b0;
        end
      endcase
      // half needs bit 0 clear, word needs bits 1:0 clear
      if (nextValid[i] && ((sizeLog2 == 2'd2 && reqAddr[i][1:0] != 2'b00) ||
                           (sizeLog2 == 2'd1 && reqAddr[i][0]))) begin
        misAlign = 1'b1;
      end
    end
    // tlb fault outranks alignment
    if (anyMapped && curFault) begin
      nextCause = causeTlb;
    end else if (misAlign) begin
      nextCause = causeAlign;
    end else begin
      nextCause = causeNone;
    end
    if (nextCause != causeNone) begin
      nextValid = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      heldValid   <= 1'b0;
      resultValid <= 1'b0;
      laneValid   <= '0;
      resultCause <= causeNone;
    end else begin
      if (tlbRsp) begin
        heldValid <= 1'b1;
      end
      resultValid <= reqValid && !(cancelValid && cancelTid == reqTid);
      laneValid   <= nextValid;
      resultCause <= nextCause;
    end
  end

  // every answer is kept, even for a cancelled op
  always_ff @(posedge clk) begin
    if (tlbRsp) begin
      heldPfn    <= tlbPfn;
      heldCached <= tlbCached;
      heldFault  <= tlbFault;
    end
    resultTid    <= reqTid;
    resultStore  <= opIsStore(reqOp);
    lanePAddr    <= nextPAddr;
    laneUncached <= nextUncached;
  end

endmodule

/* hdl/vecAddrUnit.sv */
/* Vector load/store address unit, 3 cycles from opValid to resultValid.
   The TLB must answer every tlbReq exactly one cycle later. */

`timescale 1ns/1ns

module vecAddrUnit import addrUnitPkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     opValid,
  input  memOpT    opCode,
  input  tidT      opTid,
  input  vAddrT    laneBase [NUM_LANES],
  input  vAddrT    opOffset,
  input  laneMaskT laneEn,
  input  logic     isVector,
  input  logic     isBurst,
  input  logic     cancelValid,
  input  tidT      cancelTid,
  output logic     tlbReq,
  output vpnT      tlbVpn,
  output tidT      tlbTid,
  input  logic     tlbRsp,
  input  pfnT      tlbPfn,
  input  logic     tlbCached,
  input  logic     tlbFault,
  output logic     resultValid,
  output tidT      resultTid,
  output logic     resultStore,
  output pAddrT    lanePAddr [NUM_LANES],
  output laneMaskT laneValid,
  output laneMaskT laneUncached,
  output causeT    resultCause
);

  // stage 1 to stage 2
  logic   genValid;
  memOpT  genOp;
  tidT    genTid;
  vAddrT  genAddr [NUM_LANES];
  regionT genRegion [NUM_LANES];
  // stage 2 to stage 3
  logic   reqValid;
  memOpT  reqOp;
  tidT    reqTid;
  vAddrT  reqAddr [NUM_LANES];
  regionT reqRegion [NUM_LANES];
  vpnT    reqVpn;

  addrGenStage u_gen (
    .clk, .rst_n, .opValid, .opCode, .opTid, .laneBase, .opOffset, .laneEn,
    .isVector, .isBurst, .cancelValid, .cancelTid,
    .genValid, .genOp, .genTid, .genAddr, .genRegion
  );

  tlbRequest u_req (
    .clk, .rst_n, .genValid, .genOp, .genTid, .genAddr, .genRegion,
    .cancelValid, .cancelTid, .tlbReq, .tlbVpn, .tlbTid,
    .reqValid, .reqOp, .reqTid, .reqAddr, .reqRegion, .reqVpn
  );

  addrTranslate u_xlat (
    .clk, .rst_n, .reqValid, .reqOp, .reqTid, .reqAddr, .reqRegion, .reqVpn,
    .tlbRsp, .tlbPfn, .tlbCached, .tlbFault, .cancelValid, .cancelTid,
    .resultValid, .resultTid, .resultStore, .lanePAddr, .laneValid,
    .laneUncached, .resultCause
  );

endmodule

/* test/vecAddrUnit_asserts.sv */
/* Bound checks on the TLB handshake and result outputs. Assumes the TLB
   environment answers every request on the next clock edge. */

`timescale 1ns/1ns

module vecAddrUnit_asserts import addrUnitPkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     tlbReq,
  input logic     tlbRsp,
  input logic     resultValid,
  input laneMaskT laneValid,
  input causeT    resultCause
);

  // bumped on every failed assertion
  int failCount = 0;

  // every request answered one edge later
  rspFollowsReq: assert property (@(posedge clk) disable iff (!rst_n) tlbReq |=> tlbRsp)
    else begin
      failCount++;
      $error("tlbReq got no TLB response one cycle later");
    end

  // a fault or misalignment kills every lane
  causeClearsLanes: assert property (@(posedge clk) disable iff (!rst_n)
    resultCause != causeNone |-> laneValid == '0)
    else begin
      failCount++;
      $error("laneValid is not zero while resultCause is set");
    end

  quietInReset: assert property (@(posedge clk) !rst_n |-> !resultValid)
    else begin
      failCount++;
      $error("resultValid is high during reset");
    end

endmodule

bind vecAddrUnit vecAddrUnit_asserts u_asserts (.*);

/* test/vecAddrUnitTb.sv */
/* Testbench with a one-cycle TLB model and a row-by-row reference model.
   Results are due 3 cycles after their row; the first mismatch stops the run. */

`timescale 1ns/1ns

module vecAddrUnitTb import addrUnitPkg::*; ();

  logic     clk;
  logic     rst_n;
  logic     opValid;
  memOpT    opCode;
  tidT      opTid;
  vAddrT    laneBase [NUM_LANES];
  vAddrT    opOffset;
  laneMaskT laneEn;
  logic     isVector;
  logic     isBurst;
  logic     cancelValid;
  tidT      cancelTid;
  logic     tlbReq;
  vpnT      tlbVpn;
  tidT      tlbTid;
  logic     tlbRsp = 1'b0;
  pfnT      tlbPfn = '0;
  logic     tlbCached = 1'b0;
  logic     tlbFault = 1'b0;
  logic     resultValid;
  tidT      resultTid;
  logic     resultStore;
  pAddrT    lanePAddr [NUM_LANES];
  laneMaskT laneValid;
  laneMaskT laneUncached;
  causeT    resultCause;

  // one stimulus row per cycle
  typedef struct {
    string    name;
    logic     valid;
    memOpT    op;
    tidT      tid;
    vAddrT    base [NUM_LANES];
    vAddrT    offset;
    laneMaskT en;
    logic     vec;
    logic     burst;
    logic     cancel;
    tidT      cancelTid;
  } rowT;

  typedef struct {
    string    name;
    int       due;
    tidT      tid;
    logic     store;
    pAddrT    pAddr [NUM_LANES];
    laneMaskT valid;
    laneMaskT uncached;
    causeT    cause;
  } resultT;

  rowT    rows [$];
  resultT expQ [$];
  logic   expReq [$];
  vpnT    expVpn [$];
  logic [31:0] seed = 32'h72cffe55;
  // model copy of the last requested page
  logic   mLastVld = 1'b0;
  vpnT    mLastVpn = '0;
  int     rowIdx = -1;
  int     cycles = 0;
  int     cycleLimit = 0;

  vecAddrUnit u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // TLB model answers one cycle after the request
  always @(posedge clk) begin
    tlbRsp    <= tlbReq;
    tlbPfn    <= tlbVpn ^ 20'h5A5A5;
    tlbCached <= tlbVpn[0];
    tlbFault  <= (tlbVpn[19:16] == 4'h9);
  end

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic failRun(string why);
    $display("ERROR: %s", why);
    $display("TEST FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic mismatch(string test, string what, logic [63:0] exp, logic [63:0] act);
    $display("CHECK FAILED %s %s: expected %0h actual %0h", test, what, exp, act);
    $display("TEST FAIL");
    $fatal(1, "run stopped at first mismatch");
  endtask

  task automatic checkField(string test, string what, logic [63:0] exp, logic [63:0] act);
    assert (exp === act) else mismatch(test, what, exp, act);
  endtask

  // lane i base is base + i*step plus random word offsets when rnd is set
  task automatic addRow(string name, memOpT op, tidT tid, vAddrT base, vAddrT step,
                        vAddrT off, laneMaskT en, logic vec, logic burst, logic rnd,
                        logic cxl, tidT ctid);
    rowT r;
    r.name      = name;
    r.valid     = 1'b1;
    r.op        = op;
    r.tid       = tid;
    r.offset    = off;
    r.en        = en;
    r.vec       = vec;
    r.burst     = burst;
    r.cancel    = cxl;
    r.cancelTid = ctid;
    for (int i = 0; i < NUM_LANES; i++) begin
      r.base[i] = base + vAddrT'(i) * step;
      if (rnd && i != 0) begin
        r.base[i] = r.base[i] + (nextRand() & 32'h0000_0FFC);
      end
    end
    rows.push_back(r);
  endtask

  task automatic addIdle(logic cxl, tidT ctid);
    rowT r;
    r.name      = "idle";
    r.valid     = 1'b0;
    r.op        = opLw;
    r.tid       = '0;
    r.base      = '{default: '0};
    r.offset    = '0;
    r.en        = '0;
    r.vec       = 1'b0;
    r.burst     = 1'b0;
    r.cancel    = cxl;
    r.cancelTid = ctid;
    rows.push_back(r);
  endtask

  // name, op, tid, base, step, offset, enable, vector, burst, random, cancel, cancel tid
  task automatic buildTable();
    addRow("scalar uncached", opLw,  0, 32'hA000_1000, 32'h10, 32'h4, 4'hF, 0, 0, 0, 0, 0);
    addRow("vector debug",    opLh,  1, 32'hB000_0200, 32'h100, 32'h2, 4'hB, 1, 0, 0, 0, 0);
    addRow("vector cached",   opSw,  2, 32'hC000_0000, 32'h40, 32'h0, 4'hF, 1, 0, 0, 0, 0);
    addRow("mixed regions",   opLb,  3, 32'h1000_0000, 32'h9000_0000, 0, 4'hF, 1, 0, 0, 0, 0);
    addRow("burst word",      opLw,  0, 32'hC000_0100, 32'h0, 32'h0, 4'hF, 1, 1, 0, 0, 0);
    addRow("burst half",      opSh,  1, 32'hA000_0200, 32'h10, 32'h0, 4'hF, 1, 1, 0, 0, 0);
    addRow("burst byte",      opLbu, 2, 32'hB000_0003, 32'h0, 32'h0, 4'hF, 1, 1, 0, 0, 0);
    addRow("mapped page a",   opLw,  3, 32'h4001_2000, 32'h4, 32'h0, 4'hF, 1, 0, 0, 0, 0);
    addRow("same page a",     opSw,  0, 32'h4001_2100, 32'h8, 32'h0, 4'hF, 1, 0, 0, 0, 0);
    addRow("page b split",    opLw,  1, 32'h4001_3FF8, 32'h4, 32'h0, 4'hF, 1, 0, 0, 0, 0);
    addRow("fault page",      opLw,  2, 32'h9000_0040, 32'h4, 32'h0, 4'hF, 1, 0, 0, 0, 0);
    addRow("misaligned word", opLw,  3, 32'hC000_0002, 32'h0, 32'h0, 4'h1, 0, 0, 0, 0, 0);
    addRow("fault over align", opLh, 0, 32'h9000_1001, 32'h0, 32'h0, 4'h1, 0, 0, 0, 0, 0);
    addRow("misaligned half", opLhu, 1, 32'hA000_0001, 32'h0, 32'h0, 4'h1, 1, 0, 0, 0, 0);
    addRow("random cached",   opLw,  2, 32'hC010_0000, 32'h1000, 32'h0, 4'hF, 1, 0, 1, 0, 0);
    addRow("random mapped",   opSw,  3, 32'h4002_0000, 32'h0, 32'h0, 4'hF, 1, 0, 1, 0, 0);
    addRow("t1 doomed a",     opLw,  1, 32'hC000_1000, 32'h4, 32'h0, 4'hF, 1, 0, 0, 0, 0);
    addRow("t2 kept",         opLw,  2, 32'hA000_2000, 32'h4, 32'h0, 4'hF, 1, 0, 0, 0, 0);
    addRow("t1 doomed b",     opSb,  1, 32'hB000_0010, 32'h1, 32'h0, 4'hF, 1, 0, 0, 1, 1);
    addRow("t1 after cancel", opLw,  1, 32'hC000_2000, 32'h4, 32'h0, 4'hF, 1, 0, 0, 0, 0);
    addRow("t3 mapped doomed", opLw, 3, 32'h4005_0000, 32'h4, 32'h0, 4'hF, 1, 0, 0, 0, 0);
    // cancel with no op catches t3 in stage 2
    addIdle(1, 3);
    addRow("t2 dropped",      opLw,  2, 32'h4007_0000, 32'h4, 32'h0, 4'hF, 1, 0, 0, 1, 2);
    addRow("t0 held page",    opLw,  0, 32'h4005_0010, 32'h4, 32'h0, 4'hF, 1, 0, 0, 0, 0);
    // drain the pipeline
    repeat (4) addIdle(0, 0);
  endtask

  task automatic modelRow(int k);
    rowT    r;
    resultT e;
    vAddrT  addr [NUM_LANES];
    regionT region [NUM_LANES];
    logic   hasMap;
    logic   req;
    logic   drop;
    logic   mis;
    vpnT    vpn;
    int     sz;
    r      = rows[k];
    hasMap = 1'b0;
    req    = 1'b0;
    mis    = 1'b0;
    vpn    = '0;
    sz     = (r.op inside {opLw, opSw}) ? 4 : (r.op inside {opLh, opLhu, opSh}) ? 2 : 1;
    // killed on arrival so never reaches the TLB
    drop   = !r.valid || (r.cancel && r.cancelTid == r.tid);
    for (int i = 0; i < NUM_LANES; i++) begin
      addr[i] = r.base[i] + r.offset + (r.burst ? vAddrT'(i * sz) : 32'h0);
      if (!r.en[i] || (!r.vec && i > 0) || addr[i] < VADR_MAPPED) begin
        region[i] = regNone;
      end else if (addr[i] < VADR_UNCACHED) begin
        region[i] = regMapped;
      end else if (addr[i] < VADR_DEBUG) begin
        region[i] = regUncached;
      end else if (addr[i] < VADR_CACHED) begin
        region[i] = regDebug;
      end else begin
        region[i] = regCached;
      end
      // lowest mapped lane picks the page
      if (region[i] == regMapped && !hasMap) begin
        hasMap = 1'b1;
        vpn    = addr[i][31:PAGE_BITS];
      end
    end
    if (!drop && hasMap && (!mLastVld || vpn != mLastVpn)) begin
      req      = 1'b1;
      mLastVld = 1'b1;
      mLastVpn = vpn;
    end
    expReq.push_back(req);
    expVpn.push_back(vpn);
    // cancels in the next two rows hit it in flight
    for (int j = k + 1; j <= k + 2 && j < rows.size(); j++) begin
      if (rows[j].cancel && rows[j].cancelTid == r.tid) begin
        drop = 1'b1;
      end
    end
    if (!drop) begin
      e.name     = r.name;
      e.due      = k + 3;
      e.tid      = r.tid;
      e.store    = r.op inside {opSw, opSh, opSb};
      e.valid    = '0;
      e.uncached = '0;
      e.cause    = causeNone;
      for (int i = 0; i < NUM_LANES; i++) begin
        e.pAddr[i] = '0;
        if (region[i] == regMapped && mLastVld && addr[i][31:PAGE_BITS] == vpn) begin
          e.pAddr[i]    = {mLastVpn ^ 20'h5A5A5, addr[i][PAGE_BITS-1:0]};
          e.valid[i]    = 1'b1;
          e.uncached[i] = !mLastVpn[0];
        end else if (region[i] == regUncached) begin
          e.pAddr[i]    = addr[i] - 32'hA000_0000;
          e.valid[i]    = 1'b1;
          e.uncached[i] = 1'b1;
        end else if (region[i] == regDebug) begin
          e.pAddr[i]    = 32'h1F00_0000 + addr[i] - 32'hB000_0000;
          e.valid[i]    = 1'b1;
          e.uncached[i] = 1'b1;
        end else if (region[i] == regCached) begin
          e.pAddr[i] = addr[i] - 32'hC000_0000;
          e.valid[i] = 1'b1;
        end
        if (e.valid[i] && ((sz == 4 && addr[i][1:0] != 2'b00) || (sz == 2 && addr[i][0]))) begin
          mis = 1'b1;
        end
      end
      if (hasMap && mLastVpn[19:16] == 4'h9) begin
        e.cause = causeTlb;
      end else if (mis) begin
        e.cause = causeAlign;
      end
      if (e.cause != causeNone) begin
        e.valid = '0;
      end
      expQ.push_back(e);
    end
  endtask

  task automatic driveRow(int k);
    opValid     <= rows[k].valid;
    opCode      <= rows[k].op;
    opTid       <= rows[k].tid;
    laneBase    <= rows[k].base;
    opOffset    <= rows[k].offset;
    laneEn      <= rows[k].en;
    isVector    <= rows[k].vec;
    isBurst     <= rows[k].burst;
    cancelValid <= rows[k].cancel;
    cancelTid   <= rows[k].cancelTid;
  endtask

  task automatic checkCycle();
    resultT e;
    int     k;
    // op of the previous row sits in stage 2 now
    k = rowIdx - 1;
    if (k >= 0 && k < expReq.size()) begin
      checkField(rows[k].name, "tlbReq", expReq[k], tlbReq);
      if (expReq[k]) begin
        checkField(rows[k].name, "tlbVpn", expVpn[k], tlbVpn);
        checkField(rows[k].name, "tlbTid", rows[k].tid, tlbTid);
      end
    end
    if (resultValid) begin
      assert (expQ.size() > 0) else failRun("resultValid is high with no op expected");
      e = expQ.pop_front();
      checkField(e.name, "due cycle", e.due, rowIdx);
      checkField(e.name, "resultTid", e.tid, resultTid);
      checkField(e.name, "resultStore", e.store, resultStore);
      checkField(e.name, "resultCause", e.cause, resultCause);
      checkField(e.name, "laneValid", e.valid, laneValid);
      checkField(e.name, "laneUncached", e.uncached & e.valid, laneUncached & laneValid);
      for (int i = 0; i < NUM_LANES; i++) begin
        if (e.valid[i]) begin
          checkField(e.name, $sformatf("lane %0d address", i), e.pAddr[i], lanePAddr[i]);
        end
      end
    end else begin
      assert (expQ.size() == 0 || expQ[0].due != rowIdx)
        else failRun($sformatf("op %s gave no result after 3 cycles", expQ[0].name));
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    assert (u_dut.u_asserts.failCount == 0)
      else failRun("a bound assertion on the DUT failed");
    if (rowIdx >= 0) begin
      checkCycle();
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycles = cycles + 1;
      if (cycles > cycleLimit) begin
        failRun("timeout, the run took more cycles than the stimulus table allows");
      end
    end
  end

  initial begin
    opValid     = 1'b0;
    opCode      = opLw;
    opTid       = '0;
    laneBase    = '{default: '0};
    opOffset    = '0;
    laneEn      = '0;
    isVector    = 1'b0;
    isBurst     = 1'b0;
    cancelValid = 1'b0;
    cancelTid   = '0;
    rst_n       = 1'b0;
    buildTable();
    cycleLimit = rows.size() + 20;
    for (int k = 0; k < rows.size(); k++) begin
      modelRow(k);
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (int k = 0; k < rows.size(); k++) begin
      @(posedge clk);
      rowIdx = k;
      driveRow(k);
    end
    @(posedge clk);
    if (expQ.size() == 0 && u_dut.u_asserts.failCount == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      failRun($sformatf("%0d results missing, %0d assertion failures",
                        expQ.size(), u_dut.u_asserts.failCount));
    end
  end

endmodule

/* vecAddrUnit.f */
hdl/addrUnitPkg.sv
hdl/addrGenStage.sv
hdl/tlbRequest.sv
hdl/addrTranslate.sv
hdl/vecAddrUnit.sv
test/vecAddrUnit_asserts.sv
test/vecAddrUnitTb.sv
